// ==== ai_unit_cfg.svh ====
`ifndef AI_UNIT_CFG_SVH
`define AI_UNIT_CFG_SVH

// Datapath and buffer sizes.
`define AI_DATA_BIT     32
`define AI_VEC_DEPTH    16
`define AI_IDX_BIT      5   // Holds a count of 0 to AI_VEC_DEPTH.
`define AI_CMD_DEPTH    4   // Also the initial credit count.
`define AI_CODE_BIT     3

// Micro-op codes.
`define AI_UOP_NOP      3'd0
`define AI_UOP_LDX_ONE  3'd1
`define AI_UOP_LDX_TWO  3'd2
`define AI_UOP_LDW_ONE  3'd3
`define AI_UOP_LDW_TWO  3'd4
`define AI_UOP_CLRX     3'd5
`define AI_UOP_CLRW     3'd6
`define AI_UOP_RUN      3'd7

`endif

// ==== ai_pkg.sv ====
`include "ai_unit_cfg.svh"

package ai_pkg;

    typedef logic [`AI_DATA_BIT-1:0] data_t;
    typedef logic [`AI_IDX_BIT-1:0]  vec_idx_t;
    typedef logic [`AI_CODE_BIT-1:0] uop_code_t;

    // Command word as seen at the top port and stored in the FIFO.
    typedef struct packed {
        uop_code_t code;
        data_t     op1;
        data_t     op2;
    } ai_cmd_t;

    typedef struct packed {
        logic    valid;
        ai_cmd_t cmd;
    } ai_uop_t;

    typedef struct packed {
        logic  valid;
        logic  epoch;
        data_t x;
        data_t w;
    } mul_req_t;

    typedef struct packed {
        logic  valid;
        logic  epoch;
        data_t product; // Low half of the full product.
    } mul_rsp_t;

    typedef enum logic {
        SEQ_IDLE,
        SEQ_RUN
    } seq_state_e;

endpackage

// ==== ai_multiplier_pipe3.sv ====
`timescale 1ns/1ps

`include "ai_unit_cfg.svh"

module ai_multiplier_pipe3 import ai_pkg::*; (
    input  logic     clk_i,
    input  logic     rstn_i,
    input  mul_req_t req_i,
    output mul_rsp_t rsp_o
);

localparam int HALF = `AI_DATA_BIT / 2;

logic [2:0]      valid_q;
logic [2:0]      epoch_q;
data_t           x_q;
data_t           w_q;
data_t           pp_ll_q; // Low x low, full width.
logic [HALF-1:0] pp_lh_q; // Cross terms, only their low halves reach the result.
logic [HALF-1:0] pp_hl_q;
data_t           prod_q;

always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
        valid_q <= '0;
    end else begin
        valid_q <= {valid_q[1:0], req_i.valid};
    end
end

always_ff @(posedge clk_i) begin
    epoch_q <= {epoch_q[1:0], req_i.epoch};
    x_q     <= req_i.x;
    w_q     <= req_i.w;
    pp_ll_q <= x_q[HALF-1:0] * w_q[HALF-1:0];
    pp_lh_q <= x_q[HALF-1:0] * w_q[`AI_DATA_BIT-1:HALF];
    pp_hl_q <= x_q[`AI_DATA_BIT-1:HALF] * w_q[HALF-1:0];
    prod_q  <= pp_ll_q + {pp_lh_q + pp_hl_q, {HALF{1'b0}}};
end

assign rsp_o = '{valid: valid_q[2], epoch: epoch_q[2], product: prod_q};

endmodule

// ==== ai_cmd_decoder.sv ====
`timescale 1ns/1ps

`include "ai_unit_cfg.svh"

module ai_cmd_decoder import ai_pkg::*; (
    input  logic    clk_i,
    input  logic    rstn_i,
    input  logic    cmd_valid_i,
    input  ai_cmd_t cmd_i,
    input  logic    busy_i,
    output logic    credit_o,
    output ai_uop_t uop_o
);

localparam int PTR_BIT = $clog2(`AI_CMD_DEPTH);

ai_cmd_t            fifo_q [`AI_CMD_DEPTH];
logic [PTR_BIT-1:0] wr_ptr_q;
logic [PTR_BIT-1:0] rd_ptr_q;
logic [PTR_BIT:0]   count_q;
logic               uop_valid_q;
ai_cmd_t            uop_cmd_q;
logic               push;
logic               pop;
logic               run_held;

function automatic logic [PTR_BIT-1:0] next_ptr(input logic [PTR_BIT-1:0] ptr);
    return (ptr == PTR_BIT'(`AI_CMD_DEPTH - 1)) ? '0 : ptr + 1'b1;
endfunction

// Credits guarantee a free slot for every valid command.
assign push     = cmd_valid_i;
assign run_held = uop_valid_q && (uop_cmd_q.code == `AI_UOP_RUN);
assign pop      = (count_q != '0) && !busy_i && !run_held;

always_ff @(posedge clk_i) begin
    if (push) begin
        fifo_q[wr_ptr_q] <= cmd_i;
    end
    if (pop) begin
        uop_cmd_q <= fifo_q[rd_ptr_q];
    end
end

always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
        wr_ptr_q    <= '0;
        rd_ptr_q    <= '0;
        count_q     <= '0;
        uop_valid_q <= 1'b0;
    end else begin
        if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
        if (pop)  rd_ptr_q <= next_ptr(rd_ptr_q);
        case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
        endcase
        // A popped NOP still returns its credit but issues nothing.
        uop_valid_q <= pop && (fifo_q[rd_ptr_q].code != `AI_UOP_NOP);
    end
end

assign credit_o = pop;
assign uop_o    = '{valid: uop_valid_q, cmd: uop_cmd_q};

endmodule

// ==== ai_vector_buffer.sv ====
`timescale 1ns/1ps

`include "ai_unit_cfg.svh"

module ai_vector_buffer import ai_pkg::*; (
    input  logic     clk_i,
    input  logic     rstn_i,
    input  ai_uop_t  uop_i,
    input  vec_idx_t rd_idx_i,
    output data_t    x_rd_o,
    output data_t    w_rd_o,
    output vec_idx_t x_count_o,
    output vec_idx_t w_count_o
);

localparam int       ADDR_BIT = $clog2(`AI_VEC_DEPTH);
localparam vec_idx_t DEPTH    = vec_idx_t'(`AI_VEC_DEPTH);

data_t    rd_data [2];
vec_idx_t count   [2];

// Lane 0 holds X, lane 1 holds W.
for (genvar v = 0; v < 2; v++) begin : g_lane
    localparam uop_code_t ONE_CODE = (v == 0) ? `AI_UOP_LDX_ONE : `AI_UOP_LDW_ONE;
    localparam uop_code_t TWO_CODE = (v == 0) ? `AI_UOP_LDX_TWO : `AI_UOP_LDW_TWO;
    localparam uop_code_t CLR_CODE = (v == 0) ? `AI_UOP_CLRX : `AI_UOP_CLRW;

    data_t    mem_q [`AI_VEC_DEPTH];
    vec_idx_t cnt_q;
    vec_idx_t slot2;
    logic     ld_one;
    logic     ld_two;
    logic     clr;

    assign ld_one = uop_i.valid && (uop_i.cmd.code == ONE_CODE);
    assign ld_two = uop_i.valid && (uop_i.cmd.code == TWO_CODE);
    assign clr    = uop_i.valid && (uop_i.cmd.code == CLR_CODE);
    assign slot2  = cnt_q + vec_idx_t'(1);

    // Only free slots are written, the rest of a load is dropped.
    always_ff @(posedge clk_i) begin
        if ((ld_one || ld_two) && (cnt_q < DEPTH)) begin
            mem_q[cnt_q[ADDR_BIT-1:0]] <= uop_i.cmd.op1;
        end
        if (ld_two && (slot2 < DEPTH)) begin
            mem_q[slot2[ADDR_BIT-1:0]] <= uop_i.cmd.op2;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            cnt_q <= '0;
        end else if (clr) begin
            cnt_q <= '0; // Contents are left in place.
        end else if (ld_two) begin
            cnt_q <= (cnt_q >= DEPTH - vec_idx_t'(1)) ? DEPTH : cnt_q + vec_idx_t'(2);
        end else if (ld_one) begin
            cnt_q <= (cnt_q == DEPTH) ? DEPTH : slot2;
        end
    end

    assign count[v]   = cnt_q;
    assign rd_data[v] = mem_q[rd_idx_i[ADDR_BIT-1:0]];
end

assign x_rd_o    = rd_data[0];
assign w_rd_o    = rd_data[1];
assign x_count_o = count[0];
assign w_count_o = count[1];

endmodule

// ==== ai_mac_sequencer.sv ====
`timescale 1ns/1ps

`include "ai_unit_cfg.svh"

module ai_mac_sequencer import ai_pkg::*; (
    input  logic     clk_i,
    input  logic     rstn_i,
    input  ai_uop_t  uop_i,
    input  vec_idx_t x_count_i,
    input  vec_idx_t w_count_i,
    input  data_t    x_rd_i,
    input  data_t    w_rd_i,
    output vec_idx_t rd_idx_o,
    output mul_req_t mul_req_o,
    input  mul_rsp_t mul_rsp_i,
    output logic     busy_o,
    output logic     result_valid_o,
    output data_t    result_o
);

seq_state_e state_q;
vec_idx_t   issue_idx_q;
vec_idx_t   sum_idx_q;
vec_idx_t   min_count;
data_t      acc_q;
logic       epoch_q;
logic [1:0] inflight_q; // Current-epoch products inside the multiplier.
logic       clr;
logic       run;
logic       issue;
logic       rsp_hit;
logic       done;

assign min_count = (x_count_i < w_count_i) ? x_count_i : w_count_i;

assign clr = uop_i.valid &&
             ((uop_i.cmd.code == `AI_UOP_CLRX) || (uop_i.cmd.code == `AI_UOP_CLRW));
assign run = uop_i.valid && (uop_i.cmd.code == `AI_UOP_RUN);

// Speculative issue as soon as both vectors hold the next element.
assign issue   = !clr && (issue_idx_q < min_count);
assign rsp_hit = mul_rsp_i.valid && (mul_rsp_i.epoch == epoch_q);
assign done    = (sum_idx_q == min_count) && (issue_idx_q == min_count) &&
                 (inflight_q == '0);

always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
        state_q     <= SEQ_IDLE;
        issue_idx_q <= '0;
        sum_idx_q   <= '0;
        acc_q       <= '0;
        epoch_q     <= 1'b0;
        inflight_q  <= '0;
    end else begin
        if (clr) begin
            issue_idx_q <= '0;
            sum_idx_q   <= '0;
            acc_q       <= '0;
            inflight_q  <= '0;
            // Flip only with live products, so back-to-back clears cannot
            // bring a stale epoch back into use.
            if (inflight_q != '0) epoch_q <= ~epoch_q;
        end else begin
            if (issue) issue_idx_q <= issue_idx_q + vec_idx_t'(1);
            if (rsp_hit) begin
                acc_q     <= acc_q + mul_rsp_i.product; // Wraps modulo 2^32.
                sum_idx_q <= sum_idx_q + vec_idx_t'(1);
            end
            case ({issue, rsp_hit})
                2'b10:   inflight_q <= inflight_q + 1'b1;
                2'b01:   inflight_q <= inflight_q - 1'b1;
                default: inflight_q <= inflight_q;
            endcase
        end

        case (state_q)
            SEQ_IDLE: if (run) state_q <= SEQ_RUN;
            SEQ_RUN:  if (done) state_q <= SEQ_IDLE;
            default:  state_q <= SEQ_IDLE;
        endcase
    end
end

assign rd_idx_o  = issue_idx_q;
assign mul_req_o = '{valid: issue, epoch: epoch_q, x: x_rd_i, w: w_rd_i};

assign busy_o         = (state_q == SEQ_RUN);
assign result_valid_o = (state_q == SEQ_RUN) && done;
assign result_o       = acc_q;

endmodule

// ==== ai_unit_top.sv ====
`timescale 1ns/1ps

`include "ai_unit_cfg.svh"

module ai_unit_top import ai_pkg::*; (
    input  logic    clk_i,
    input  logic    rstn_i,
    input  logic    cmd_valid_i,
    input  ai_cmd_t cmd_i,
    output logic    credit_o,
    output logic    result_valid_o,
    output data_t   result_o
);

ai_uop_t  uop;
logic     busy;
vec_idx_t x_count;
vec_idx_t w_count;
vec_idx_t rd_idx;
data_t    x_rd;
data_t    w_rd;
mul_req_t mul_req;
mul_rsp_t mul_rsp;

ai_cmd_decoder i_decoder (
    .clk_i       ( clk_i ),
    .rstn_i      ( rstn_i ),
    .cmd_valid_i ( cmd_valid_i ),
    .cmd_i       ( cmd_i ),
    .busy_i      ( busy ),
    .credit_o    ( credit_o ),
    .uop_o       ( uop )
);

ai_vector_buffer i_buffer (
    .clk_i     ( clk_i ),
    .rstn_i    ( rstn_i ),
    .uop_i     ( uop ),
    .rd_idx_i  ( rd_idx ),
    .x_rd_o    ( x_rd ),
    .w_rd_o    ( w_rd ),
    .x_count_o ( x_count ),
    .w_count_o ( w_count )
);

ai_mac_sequencer i_sequencer (
    .clk_i          ( clk_i ),
    .rstn_i         ( rstn_i ),
    .uop_i          ( uop ),
    .x_count_i      ( x_count ),
    .w_count_i      ( w_count ),
    .x_rd_i         ( x_rd ),
    .w_rd_i         ( w_rd ),
    .rd_idx_o       ( rd_idx ),
    .mul_req_o      ( mul_req ),
    .mul_rsp_i      ( mul_rsp ),
    .busy_o         ( busy ),
    .result_valid_o ( result_valid_o ),
    .result_o       ( result_o )
);

ai_multiplier_pipe3 i_multiplier (
    .clk_i  ( clk_i ),
    .rstn_i ( rstn_i ),
    .req_i  ( mul_req ),
    .rsp_o  ( mul_rsp )
);

endmodule

// ==== tb_ai_checker.sv ====
`timescale 1ns/1ps

`include "ai_unit_cfg.svh"

module tb_ai_checker import ai_pkg::*; (
    input  logic    clk_i,
    input  logic    rstn_i,
    input  logic    cmd_valid_i,
    input  ai_cmd_t cmd_i,
    input  logic    credit_i,
    input  logic    result_valid_i,
    input  data_t   result_i,
    input  logic    drain_i,
    output logic    done_o,
    output int      checked_o,
    output int      value_errs_o,
    output int      other_errs_o
);

data_t x_mem [`AI_VEC_DEPTH];
data_t w_mem [`AI_VEC_DEPTH];
int    x_cnt;
int    w_cnt;
data_t exp_q [$];   // One entry per RUN still waiting for its pulse.
data_t exp_val;
int    outstanding;
int    sent;
int    returned;
bit    any_sent;

function automatic void push_elem(input bit to_w, input data_t d);
    if (to_w) begin
        if (w_cnt < `AI_VEC_DEPTH) begin
            w_mem[w_cnt] = d;
            w_cnt++;
        end
    end else if (x_cnt < `AI_VEC_DEPTH) begin
        x_mem[x_cnt] = d;
        x_cnt++;
    end
endfunction

// Sum of X[i] * W[i] over the shorter vector, low 32 bits only.
function automatic data_t expected_dot();
    data_t acc;
    int    n;
    acc = '0;
    n   = (x_cnt < w_cnt) ? x_cnt : w_cnt;
    for (int i = 0; i < n; i++) begin
        acc = acc + x_mem[i] * w_mem[i];
    end
    return acc;
endfunction

always @(posedge clk_i) begin
    if (!rstn_i) begin
        x_cnt        = 0;
        w_cnt        = 0;
        outstanding  = 0;
        sent         = 0;
        returned     = 0;
        any_sent     = 1'b0;
        checked_o    = 0;
        value_errs_o = 0;
        other_errs_o = 0;
        done_o      <= 1'b0;
        exp_q.delete();
    end else begin
        if (!any_sent && (credit_i !== 1'b0 || result_valid_i !== 1'b0)) begin
            $display("Credit or result pulse seen before any command was sent at %0t", $time);
            other_errs_o++;
        end

        // Results first, a RUN accepted at this edge cannot own this pulse.
        if (result_valid_i) begin
            if (exp_q.size() == 0) begin
                $display("Result pulse at %0t with no RUN waiting for it", $time);
                other_errs_o++;
            end else begin
                exp_val = exp_q.pop_front();
                checked_o++;
                if (result_i !== exp_val) begin
                    $display("ERR %0t: result 0x%h, expected 0x%h", $time, result_i, exp_val);
                    value_errs_o++;
                end
            end
        end

        if (credit_i) begin
            returned++;
            outstanding--;
        end
        if (cmd_valid_i) begin
            sent++;
            outstanding++;
            any_sent = 1'b1;
            case (cmd_i.code)
                `AI_UOP_LDX_ONE: push_elem(1'b0, cmd_i.op1);
                `AI_UOP_LDX_TWO: begin
                    push_elem(1'b0, cmd_i.op1);
                    push_elem(1'b0, cmd_i.op2);
                end
                `AI_UOP_LDW_ONE: push_elem(1'b1, cmd_i.op1);
                `AI_UOP_LDW_TWO: begin
                    push_elem(1'b1, cmd_i.op1);
                    push_elem(1'b1, cmd_i.op2);
                end
                `AI_UOP_CLRX:    x_cnt = 0;
                `AI_UOP_CLRW:    w_cnt = 0;
                `AI_UOP_RUN:     exp_q.push_back(expected_dot());
                default: ;
            endcase
        end
        if (outstanding < 0 || outstanding > `AI_CMD_DEPTH) begin
            $display("Outstanding command count %0d out of range at %0t", outstanding, $time);
            other_errs_o++;
        end

        if (drain_i && !done_o) begin
            if (exp_q.size() != 0) begin
                $display("%0d RUN command(s) never produced a result", exp_q.size());
                other_errs_o++;
            end
            if (sent != returned) begin
                $display("Credits returned (%0d) differ from commands sent (%0d)", returned, sent);
                other_errs_o++;
            end
            done_o <= 1'b1;
        end
    end
end

endmodule

// ==== tb_ai_unit.sv ====
`timescale 1ns/1ps

`include "ai_unit_cfg.svh"

module tb_ai_unit import ai_pkg::*; ();

localparam int CLK_PERIOD     = 40;
localparam int SEQ_COUNT      = 40;
localparam int CREDIT_TIMEOUT = 200;
localparam int RESULT_TIMEOUT = 400;
localparam int DRAIN_TIMEOUT  = 20;

logic    clk_i;
logic    rstn_i;
logic    cmd_valid_i;
ai_cmd_t cmd_i;
logic    credit_o;
logic    result_valid_o;
data_t   result_o;
logic    drain_req;
logic    check_done;
int      checked;
int      value_errs;
int      other_errs;
int      credits;
bit      timed_out;

ai_unit_top i_dut (
    .clk_i          ( clk_i ),
    .rstn_i         ( rstn_i ),
    .cmd_valid_i    ( cmd_valid_i ),
    .cmd_i          ( cmd_i ),
    .credit_o       ( credit_o ),
    .result_valid_o ( result_valid_o ),
    .result_o       ( result_o )
);

tb_ai_checker i_checker (
    .clk_i          ( clk_i ),
    .rstn_i         ( rstn_i ),
    .cmd_valid_i    ( cmd_valid_i ),
    .cmd_i          ( cmd_i ),
    .credit_i       ( credit_o ),
    .result_valid_i ( result_valid_o ),
    .result_i       ( result_o ),
    .drain_i        ( drain_req ),
    .done_o         ( check_done ),
    .checked_o      ( checked ),
    .value_errs_o   ( value_errs ),
    .other_errs_o   ( other_errs )
);

initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
end

// Sender side credit count.
always @(posedge clk_i) begin
    if (!rstn_i) credits <= `AI_CMD_DEPTH;
    else         credits <= credits + int'(credit_o) - int'(cmd_valid_i);
end

task automatic idle_cycle();
    cmd_valid_i = 1'b0;
    @(posedge clk_i);
    #2;
endtask

task automatic wait_credit();
    int waited;
    waited = 0;
    while (credits == 0 && !timed_out) begin
        if (waited == CREDIT_TIMEOUT) begin
            $display("Timeout: no credit came back within %0d cycles", CREDIT_TIMEOUT);
            timed_out = 1'b1;
        end else begin
            idle_cycle();
            waited++;
        end
    end
endtask

task automatic send_cmd(input uop_code_t op_code, input data_t a_val, input data_t b_val);
    wait_credit();
    if (!timed_out) begin
        cmd_valid_i = 1'b1;
        cmd_i       = '{code: op_code, op1: a_val, op2: b_val};
        @(posedge clk_i);
        #2;
        cmd_valid_i = 1'b0;
    end
endtask

task automatic wait_result();
    int waited;
    bit seen;
    waited = 0;
    seen   = 1'b0;
    while (!seen && !timed_out) begin
        if (waited == RESULT_TIMEOUT) begin
            $display("Timeout: RUN gave no result within %0d cycles", RESULT_TIMEOUT);
            timed_out = 1'b1;
        end else begin
            @(negedge clk_i); // Mid-cycle, the pulse is stable here.
            seen = result_valid_o;
            waited++;
        end
    end
    if (seen) begin
        @(posedge clk_i);
        #2;
    end
endtask

task automatic run_sequence(input bit empty_w);
    int nx;
    int nw;
    int clr_at;
    int step;
    bit use_x;
    bit two;
    send_cmd(`AI_UOP_CLRX, '0, '0);
    send_cmd(`AI_UOP_CLRW, '0, '0);
    nx     = $urandom_range(20);   // Up to 20, so some loads overflow.
    nw     = empty_w ? 0 : $urandom_range(20);
    clr_at = ($urandom_range(3) == 0) ? $urandom_range(nx + nw) : -1;
    step   = 0;
    while ((nx > 0 || nw > 0) && !timed_out) begin
        if (step == clr_at) begin
            send_cmd($urandom_range(1) ? `AI_UOP_CLRX : `AI_UOP_CLRW, '0, '0);
        end
        use_x = (nw == 0) || (nx > 0 && $urandom_range(1) == 1);
        two   = ($urandom_range(1) == 1) && ((use_x ? nx : nw) >= 2);
        if (use_x) begin
            send_cmd(two ? `AI_UOP_LDX_TWO : `AI_UOP_LDX_ONE, $urandom, $urandom);
            nx -= two ? 2 : 1;
        end else begin
            send_cmd(two ? `AI_UOP_LDW_TWO : `AI_UOP_LDW_ONE, $urandom, $urandom);
            nw -= two ? 2 : 1;
        end
        if ($urandom_range(15) == 0) send_cmd(`AI_UOP_NOP, $urandom, $urandom);
        if ($urandom_range(7) == 0) idle_cycle();
        step++;
    end
    send_cmd(`AI_UOP_RUN, '0, '0);
    if (!timed_out) wait_result();
endtask

task automatic wait_all_credits();
    int waited;
    waited = 0;
    while (credits != `AI_CMD_DEPTH && !timed_out) begin
        if (waited == CREDIT_TIMEOUT) begin
            $display("Timeout: credits did not all come back");
            timed_out = 1'b1;
        end else begin
            idle_cycle();
            waited++;
        end
    end
endtask

task automatic wait_check_done();
    int waited;
    waited = 0;
    while (!check_done && !timed_out) begin
        if (waited == DRAIN_TIMEOUT) begin
            $display("Timeout: checker did not finish its final checks");
            timed_out = 1'b1;
        end else begin
            @(negedge clk_i);
            waited++;
        end
    end
endtask

initial begin
    void'($urandom(32'hd54901fb));
    rstn_i      = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_i       = '0;
    drain_req   = 1'b0;
    timed_out   = 1'b0;
    repeat (2) @(posedge clk_i);
    #2;
    rstn_i = 1'b1;
    repeat (3) idle_cycle();   // Quiet outputs expected here.
    for (int s = 0; s < SEQ_COUNT && !timed_out; s++) begin
        run_sequence(s % 10 == 0);
    end
    wait_all_credits();
    if (!timed_out) begin
        drain_req = 1'b1;
        wait_check_done();
    end
    $display("Results checked: %0d, value errors: %0d, other errors: %0d",
             checked, value_errs, other_errs);
    if (timed_out || value_errs != 0 || other_errs != 0) begin
        $display("Errors found");
    end else begin
        $display("No errors");
    end
    $finish;
end

endmodule

// ==== files.f ====
+incdir+.
ai_pkg.sv
ai_multiplier_pipe3.sv
ai_cmd_decoder.sv
ai_vector_buffer.sv
ai_mac_sequencer.sv
ai_unit_top.sv
tb_ai_checker.sv
tb_ai_unit.sv

// ==== Bender.yml ====
package:
  name: ai_unit

export_include_dirs:
  - .

sources:
  - ai_pkg.sv
  - ai_multiplier_pipe3.sv
  - ai_cmd_decoder.sv
  - ai_vector_buffer.sv
  - ai_mac_sequencer.sv
  - ai_unit_top.sv
  - target: test
    files:
      - tb_ai_checker.sv
      - tb_ai_unit.sv
